//--- bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 5;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset high for the first few edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- bench/mem_path_assert.sv
`timescale 1ns/100ps

module mem_path_assert import mem_path_pkg::*; (
	input logic clk,
	input logic rst,
	input logic arvalid,
	input addr_t araddr,
	input logic arready,
	input logic rvalid,
	input logic awvalid,
	input addr_t awaddr,
	input logic awready,
	input logic wvalid,
	input data_t wdata,
	input strb_t wstrb,
	input logic wready,
	input logic bvalid
);

	// request channels hold until taken
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("read address dropped or changed before its handshake");

	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("write address dropped or changed before its handshake");

	w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("write data dropped or changed before its handshake");

	// address and data of a write go up as a pair
	aw_with_w: assert property (@(posedge clk) disable iff (rst)
		$rose(awvalid) |-> $rose(wvalid))
		else $error("awvalid rose without wvalid");

	w_with_aw: assert property (@(posedge clk) disable iff (rst)
		$rose(wvalid) |-> $rose(awvalid))
		else $error("wvalid rose without awvalid");

	// no response out of a slave held in reset
	reset_quiet: assert property (@(posedge clk)
		rst |=> !rvalid && !bvalid)
		else $error("response valid high during reset");

endmodule

bind axi_sram mem_path_assert mem_path_assert_inst (
	.clk(clk),
	.rst(rst),
	.arvalid(arvalid),
	.araddr(araddr),
	.arready(arready),
	.rvalid(rvalid),
	.awvalid(awvalid),
	.awaddr(awaddr),
	.awready(awready),
	.wvalid(wvalid),
	.wdata(wdata),
	.wstrb(wstrb),
	.wready(wready),
	.bvalid(bvalid)
);

//--- bench/mem_path_tb.sv
`timescale 1ns/100ps
`include "mem_path_consts.svh"

module mem_path_tb import mem_path_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int N_RANDOM = 2000;
	// upper bound on the hand-written commands
	localparam int N_DIRECTED = 64;
	localparam int MEM_BYTES = `MEM_WORDS * 8;
	// fill pass, directed and random commands at 20 cycles each
	localparam int TOTAL_CMDS = `MEM_WORDS + N_DIRECTED + N_RANDOM;
	localparam int TIMEOUT_NS = (TOTAL_CMDS * 20 + RESET_CYCLES) * CLK_PERIOD;

	logic clk;
	logic rst;
	logic cmd_valid;
	logic cmd_write;
	mem_size_t cmd_size;
	logic cmd_unsigned;
	addr_t cmd_addr;
	data_t cmd_wdata;
	logic busy;
	logic res_valid;
	data_t res_data;
	logic res_err;

	// reference memory, one entry per byte
	logic [7:0] model_mem [MEM_BYTES];
	// expected results, oldest first
	data_t exp_data_q [$];
	logic exp_err_q [$];
	data_t want_data;
	logic want_err;

	integer seed = 7022;
	int result_count = 0;
	int mismatch_count = 0;
	int unexpected_count = 0;

	clk_gen clk_gen_inst (
		.clk(clk),
		.rst(rst)
	);

	mem_path_top mem_path_top_inst (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_write(cmd_write),
		.cmd_size(cmd_size),
		.cmd_unsigned(cmd_unsigned),
		.cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata),
		.busy(busy),
		.res_valid(res_valid),
		.res_data(res_data),
		.res_err(res_err)
	);

	function automatic int size_bytes(mem_size_t sz);
		return 1 << sz;
	endfunction

	// start address not a multiple of the size
	function automatic logic is_misaligned(addr_t addr, mem_size_t sz);
		addr_t mask;
		mask = addr_t'(size_bytes(sz) - 1);
		return (addr & mask) != '0;
	endfunction

	// pattern built from every address bit
	function automatic data_t fill_word(addr_t addr);
		return {addr ^ 32'ha5c3_0f96, (addr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c};
	endfunction

	// update the model and queue what the DUT should return
	task automatic model_accept(logic wr, mem_size_t sz, logic uns, addr_t addr, data_t wd);
		int nbytes;
		int base;
		data_t val;
		logic err;
		nbytes = size_bytes(sz);
		base = int'(addr);
		val = '0;
		err = 1'b0;
		if (is_misaligned(addr, sz) || addr >= addr_t'(MEM_BYTES)) begin
			err = 1'b1;
		end else if (wr) begin
			for (int i = 0; i < nbytes; i++) begin
				model_mem[base + i] = wd[8*i +: 8];
			end
		end else begin
			for (int i = 0; i < nbytes; i++) begin
				val[8*i +: 8] = model_mem[base + i];
			end
			// signed load copies the top bit upward
			if (!uns && val[8*nbytes-1]) begin
				val = val | (~64'h0 << (8 * nbytes));
			end
		end
		exp_data_q.push_back(val);
		exp_err_q.push_back(err);
	endtask

	// results checked first, then the command taken at this edge
	always @(posedge clk) begin
		if (!rst) begin
			if (res_valid) begin
				result_count++;
				assert (exp_data_q.size() != 0) else begin
					unexpected_count++;
					$display("unexpected result at time %0t: data %h err %b, no command open",
						$time, res_data, res_err);
				end
				if (exp_data_q.size() != 0) begin
					want_data = exp_data_q.pop_front();
					want_err = exp_err_q.pop_front();
					assert (res_err === want_err) else begin
						mismatch_count++;
						$display("Mismatch at time %0t: res_err %b, expected %b",
							$time, res_err, want_err);
					end
					assert (res_data === want_data) else begin
						mismatch_count++;
						$display("Mismatch at time %0t: res_data %h, expected %h",
							$time, res_data, want_data);
					end
				end
			end
			if (cmd_valid && !busy) begin
				model_accept(cmd_write, cmd_size, cmd_unsigned, cmd_addr, cmd_wdata);
			end
		end
	end

	// called at a rising edge, returns at the edge that takes the command
	task automatic send_cmd(logic wr, mem_size_t sz, logic uns, addr_t addr, data_t wd);
		cmd_valid <= 1'b1;
		cmd_write <= wr;
		cmd_size <= sz;
		cmd_unsigned <= uns;
		cmd_addr <= addr;
		cmd_wdata <= wd;
		@(posedge clk);
		while (busy) begin
			@(posedge clk);
		end
		cmd_valid <= 1'b0;
	endtask

	// every word written once so loads never see X
	task automatic fill_memory();
		addr_t addr;
		for (int w = 0; w < `MEM_WORDS; w++) begin
			addr = addr_t'(8 * w);
			send_cmd(1'b1, `SIZE_D, 1'b0, addr, fill_word(addr));
		end
	endtask

	// store then load back, all sizes, both extensions
	task automatic store_load_pairs();
		int nbytes;
		addr_t addr;
		data_t wd;
		for (int sz = 0; sz < 4; sz++) begin
			for (int uns = 0; uns < 2; uns++) begin
				nbytes = 1 << sz;
				// top lane that still fits the size
				addr = addr_t'(64 + 16 * (2 * sz + uns) + (8 - nbytes));
				wd = {$random(seed), $random(seed)};
				wd = wd | (64'h80 << (8 * (nbytes - 1)));
				send_cmd(1'b1, mem_size_t'(sz), 1'b0, addr, wd);
				send_cmd(1'b0, mem_size_t'(sz), uns[0], addr, '0);
			end
		end
	endtask

	// narrow stores leave the other lanes alone
	task automatic lane_isolation();
		addr_t base;
		base = addr_t'(8 * 100);
		send_cmd(1'b0, `SIZE_D, 1'b0, base, '0);
		send_cmd(1'b1, `SIZE_B, 1'b0, base + 3, 64'h5a);
		send_cmd(1'b1, `SIZE_H, 1'b0, base + 6, 64'hc3e1);
		send_cmd(1'b0, `SIZE_D, 1'b0, base, '0);
		send_cmd(1'b0, `SIZE_W, 1'b1, base + 4, '0);
	endtask

	// misaligned stores must not reach memory
	task automatic misaligned_access();
		addr_t base;
		base = addr_t'(8 * 120);
		send_cmd(1'b1, `SIZE_H, 1'b0, base + 1, 64'hffff);
		send_cmd(1'b1, `SIZE_W, 1'b0, base + 10, 64'hffff_ffff);
		send_cmd(1'b1, `SIZE_D, 1'b0, base + 20, '1);
		send_cmd(1'b0, `SIZE_W, 1'b0, base + 1, '0);
		send_cmd(1'b0, `SIZE_D, 1'b0, base, '0);
		send_cmd(1'b0, `SIZE_D, 1'b0, base + 8, '0);
		send_cmd(1'b0, `SIZE_D, 1'b0, base + 16, '0);
	endtask

	// beyond the array, then the word with the same low index bits
	task automatic out_of_range_access();
		addr_t far;
		far = addr_t'(MEM_BYTES + 8 * 40);
		send_cmd(1'b1, `SIZE_D, 1'b0, far, 64'hdead_beef_0bad_f00d);
		send_cmd(1'b0, `SIZE_D, 1'b0, far, '0);
		send_cmd(1'b0, `SIZE_B, 1'b1, 32'hffff_fff8, '0);
		send_cmd(1'b0, `SIZE_D, 1'b0, addr_t'(8 * 40), '0);
	endtask

	task automatic random_cmd();
		int pick;
		int where;
		mem_size_t sz;
		addr_t addr;
		data_t wd;
		pick = $random(seed);
		where = $random(seed);
		sz = mem_size_t'(pick[2:1]);
		wd = {$random(seed), $random(seed)};
		// mostly a small hot window, some full range, few beyond
		if (where[3:0] == 4'd0) begin
			addr = addr_t'(MEM_BYTES) + ((addr_t'(where) >> 4) % 32'h1000);
		end else if (where[3:0] < 4'd9) begin
			addr = (addr_t'(where) >> 4) % 32'd128;
		end else begin
			addr = (addr_t'(where) >> 4) % addr_t'(MEM_BYTES);
		end
		// one in sixteen left misaligned
		if (pick[7:4] != 4'd0) begin
			addr = addr & ~addr_t'(size_bytes(sz) - 1);
		end
		send_cmd(pick[0], sz, pick[3], addr, wd);
		if (pick[10:8] == 3'd0) begin
			repeat (1 + pick[12:11]) @(posedge clk);
		end
	endtask

	task automatic wait_drain();
		@(posedge clk);
		while (exp_data_q.size() != 0) begin
			@(posedge clk);
		end
		// catch stray extra results
		repeat (4) @(posedge clk);
	endtask

	initial begin
		cmd_valid = 1'b0;
		cmd_write = 1'b0;
		cmd_size = `SIZE_B;
		cmd_unsigned = 1'b0;
		cmd_addr = '0;
		cmd_wdata = '0;
		@(posedge clk);
		while (rst) begin
			@(posedge clk);
		end
		fill_memory();
		store_load_pairs();
		lane_isolation();
		misaligned_access();
		out_of_range_access();
		for (int n = 0; n < N_RANDOM; n++) begin
			random_cmd();
		end
		wait_drain();
		$display("summary: %0d results, %0d mismatches, %0d unexpected results",
			result_count, mismatch_count, unexpected_count);
		if (mismatch_count == 0 && unexpected_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// hung pipeline or lost result
	initial begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns with %0d results still outstanding",
			TIMEOUT_NS, exp_data_q.size());
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- logic/axi_lite_master.sv
`timescale 1ns/100ps
`include "mem_path_consts.svh"

module axi_lite_master import mem_path_pkg::*; (
	input logic clk,
	input logic rst,
	input logic a_valid,
	input logic a_write,
	input addr_t a_addr,
	input strb_t a_strb,
	input data_t a_wdata,
	input lane_t a_lane,
	input mem_size_t a_size,
	input logic a_unsigned,
	input logic a_misaligned,
	output logic a_take,
	output logic arvalid,
	output addr_t araddr,
	input logic arready,
	input logic rvalid,
	input data_t rdata,
	input resp_t rresp,
	output logic rready,
	output logic awvalid,
	output addr_t awaddr,
	input logic awready,
	output logic wvalid,
	output data_t wdata,
	output strb_t wstrb,
	input logic wready,
	input logic bvalid,
	input resp_t bresp,
	output logic bready,
	output logic m_valid,
	output data_t m_rdata,
	output logic m_err,
	output logic m_write,
	output lane_t m_lane,
	output mem_size_t m_size,
	output logic m_unsigned
);

	master_state_t state;
	addr_t req_addr;

	// one entry at a time, only from idle
	assign a_take = a_valid && (state == ms_idle);

	// responses always accepted
	assign rready = 1'b1;
	assign bready = 1'b1;

	// both address channels share one register
	assign araddr = req_addr;
	assign awaddr = req_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ms_idle;
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			m_valid <= 1'b0;
		end else begin
			m_valid <= 1'b0;
			case (state)
				ms_idle: begin
					if (a_take && a_misaligned) begin
						// no bus traffic, error straight downstream
						m_valid <= 1'b1;
					end else if (a_take && a_write) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						state <= ms_write_wait;
					end else if (a_take) begin
						arvalid <= 1'b1;
						state <= ms_read_wait;
					end
				end
				ms_read_wait: begin
					if (arready) begin
						arvalid <= 1'b0;
					end
					if (rvalid) begin
						m_valid <= 1'b1;
						state <= ms_idle;
					end
				end
				ms_write_wait: begin
					// slave takes both together
					if (awready) begin
						awvalid <= 1'b0;
					end
					if (wready) begin
						wvalid <= 1'b0;
					end
					if (bvalid) begin
						m_valid <= 1'b1;
						state <= ms_idle;
					end
				end
				default: begin
					state <= ms_idle;
				end
			endcase
		end
	end

	// request payload and the side info for the result stage
	always_ff @(posedge clk) begin
		if (a_take) begin
			req_addr <= a_addr;
			wdata <= a_wdata;
			wstrb <= a_strb;
			m_write <= a_write;
			m_lane <= a_lane;
			m_size <= a_size;
			m_unsigned <= a_unsigned;
			m_rdata <= '0;
			m_err <= a_misaligned;
		end else if (state == ms_read_wait && rvalid) begin
			m_rdata <= rdata;
			m_err <= (rresp != `RESP_OKAY);
		end else if (state == ms_write_wait && bvalid) begin
			m_err <= (bresp != `RESP_OKAY);
		end
	end

endmodule

//--- logic/axi_sram.sv
`timescale 1ns/100ps
`include "mem_path_consts.svh"

module axi_sram import mem_path_pkg::*; (
	input logic clk,
	input logic rst,
	input logic arvalid,
	input addr_t araddr,
	output logic arready,
	output logic rvalid,
	output data_t rdata,
	output resp_t rresp,
	input logic rready,
	input logic awvalid,
	input addr_t awaddr,
	output logic awready,
	input logic wvalid,
	input data_t wdata,
	input strb_t wstrb,
	output logic wready,
	output logic bvalid,
	output resp_t bresp,
	input logic bready
);

	localparam int IDX_W = $clog2(`MEM_WORDS);

	data_t mem [`MEM_WORDS];

	sram_rd_state_t rd_state;
	sram_wr_state_t wr_state;

	logic rd_hs;
	logic wr_hs;
	logic rd_in_range;
	logic wr_in_range;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	// word index from the byte address
	assign rd_idx = araddr[IDX_W+2:3];
	assign wr_idx = awaddr[IDX_W+2:3];
	assign rd_in_range = (araddr[`ADDR_W-1:3] < `MEM_WORDS);
	assign wr_in_range = (awaddr[`ADDR_W-1:3] < `MEM_WORDS);

	// read side ready only when idle
	assign arready = (rd_state == sr_idle);
	assign rvalid = (rd_state == sr_respond);
	assign rd_hs = arvalid && arready;

	// address and data only accepted as a pair
	assign awready = (wr_state == sw_idle) && wvalid;
	assign wready = (wr_state == sw_idle) && awvalid;
	assign bvalid = (wr_state == sw_respond);
	assign wr_hs = awvalid && awready;

	// read FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= sr_idle;
		end else begin
			case (rd_state)
				sr_idle: begin
					if (rd_hs) begin
						rd_state <= sr_respond;
					end
				end
				sr_respond: begin
					if (rready) begin
						rd_state <= sr_idle;
					end
				end
				default: begin
					rd_state <= sr_idle;
				end
			endcase
		end
	end

	// write FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= sw_idle;
		end else begin
			case (wr_state)
				sw_idle: begin
					if (wr_hs) begin
						wr_state <= sw_respond;
					end
				end
				sw_respond: begin
					if (bready) begin
						wr_state <= sw_idle;
					end
				end
				default: begin
					wr_state <= sw_idle;
				end
			endcase
		end
	end

	// read data, zero and error beyond the array
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata <= rd_in_range ? mem[rd_idx] : '0;
			rresp <= rd_in_range ? `RESP_OKAY : `RESP_SLVERR;
		end
	end

	// byte lanes picked by wstrb
	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bresp <= wr_in_range ? `RESP_OKAY : `RESP_SLVERR;
			if (wr_in_range) begin
				for (int i = 0; i < `STRB_W; i++) begin
					if (wstrb[i]) begin
						mem[wr_idx][i*8 +: 8] <= wdata[i*8 +: 8];
					end
				end
			end
		end
	end

endmodule

//--- logic/load_extract.sv
`timescale 1ns/100ps
`include "mem_path_consts.svh"

module load_extract import mem_path_pkg::*; (
	input logic clk,
	input logic rst,
	input logic m_valid,
	input data_t m_rdata,
	input logic m_err,
	input logic m_write,
	input lane_t m_lane,
	input mem_size_t m_size,
	input logic m_unsigned,
	output logic res_valid,
	output data_t res_data,
	output logic res_err
);

	data_t shifted;
	data_t extended;

	// bring the addressed lane down to bit 0
	assign shifted = m_rdata >> {m_lane, 3'b000};

	// sign or zero fill by size
	always_comb begin
		case (m_size)
			`SIZE_B: begin
				extended = {{56{shifted[7] & ~m_unsigned}}, shifted[7:0]};
			end
			`SIZE_H: begin
				extended = {{48{shifted[15] & ~m_unsigned}}, shifted[15:0]};
			end
			`SIZE_W: begin
				extended = {{32{shifted[31] & ~m_unsigned}}, shifted[31:0]};
			end
			default: begin
				extended = shifted;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= m_valid;
		end
	end

	// stores and errors return zero
	always_ff @(posedge clk) begin
		if (m_valid) begin
			res_data <= (m_write || m_err) ? '0 : extended;
			res_err <= m_err;
		end
	end

endmodule

//--- logic/lsu_align.sv
`timescale 1ns/100ps
`include "mem_path_consts.svh"

module lsu_align import mem_path_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input logic cmd_write,
	input mem_size_t cmd_size,
	input logic cmd_unsigned,
	input addr_t cmd_addr,
	input data_t cmd_wdata,
	output logic busy,
	input logic a_take,
	output logic a_valid,
	output logic a_write,
	output addr_t a_addr,
	output strb_t a_strb,
	output data_t a_wdata,
	output lane_t a_lane,
	output mem_size_t a_size,
	output logic a_unsigned,
	output logic a_misaligned
);

	logic accept;
	logic misaligned;
	strb_t base_strb;
	lane_t lane;

	// full while an entry sits here and the master leaves it
	assign busy = a_valid && !a_take;
	assign accept = cmd_valid && !busy;
	assign lane = cmd_addr[2:0];

	// low address bits against the access size
	always_comb begin
		case (cmd_size)
			`SIZE_B: begin
				misaligned = 1'b0;
				base_strb = 8'h01;
			end
			`SIZE_H: begin
				misaligned = cmd_addr[0];
				base_strb = 8'h03;
			end
			`SIZE_W: begin
				misaligned = |cmd_addr[1:0];
				base_strb = 8'h0f;
			end
			default: begin
				misaligned = |cmd_addr[2:0];
				base_strb = 8'hff;
			end
		endcase
	end

	// entry valid flag
	always_ff @(posedge clk) begin
		if (rst) begin
			a_valid <= 1'b0;
		end else if (accept) begin
			a_valid <= 1'b1;
		end else if (a_take) begin
			a_valid <= 1'b0;
		end
	end

	// entry payload, loaded on acceptance only
	always_ff @(posedge clk) begin
		if (accept) begin
			a_write <= cmd_write;
			a_addr <= {cmd_addr[`ADDR_W-1:3], 3'b000};
			// strobe and data moved up to the lane
			a_strb <= base_strb << lane;
			a_wdata <= cmd_wdata << {lane, 3'b000};
			a_lane <= lane;
			a_size <= cmd_size;
			a_unsigned <= cmd_unsigned;
			a_misaligned <= misaligned;
		end
	end

endmodule

//--- logic/mem_path_consts.svh
`ifndef MEM_PATH_CONSTS_SVH
`define MEM_PATH_CONSTS_SVH

// bus and data widths
`define ADDR_W 32
`define DATA_W 64
`define STRB_W 8

// memory depth in 64-bit words
`define MEM_WORDS 512

// access size codes
`define SIZE_B 2'd0
`define SIZE_H 2'd1
`define SIZE_W 2'd2
`define SIZE_D 2'd3

// bus response codes
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`endif

//--- logic/mem_path_pkg.sv
`include "mem_path_consts.svh"

package mem_path_pkg;

	// plain vectors with a meaning
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [`STRB_W-1:0] strb_t;
	typedef logic [1:0] mem_size_t;
	typedef logic [1:0] resp_t;
	// byte lane inside one word
	typedef logic [2:0] lane_t;

	// bus master
	typedef enum logic [1:0] {
		ms_idle,
		ms_read_wait,
		ms_write_wait
	} master_state_t;

	// slave read and write sides
	typedef enum logic {
		sr_idle,
		sr_respond
	} sram_rd_state_t;

	typedef enum logic {
		sw_idle,
		sw_respond
	} sram_wr_state_t;

endpackage

//--- logic/mem_path_top.sv
`timescale 1ns/100ps

module mem_path_top import mem_path_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input logic cmd_write,
	input mem_size_t cmd_size,
	input logic cmd_unsigned,
	input addr_t cmd_addr,
	input data_t cmd_wdata,
	output logic busy,
	output logic res_valid,
	output data_t res_data,
	output logic res_err
);

	// align to master
	logic a_valid;
	logic a_take;
	logic a_write;
	addr_t a_addr;
	strb_t a_strb;
	data_t a_wdata;
	lane_t a_lane;
	mem_size_t a_size;
	logic a_unsigned;
	logic a_misaligned;

	// bus
	logic arvalid;
	addr_t araddr;
	logic arready;
	logic rvalid;
	data_t rdata;
	resp_t rresp;
	logic rready;
	logic awvalid;
	addr_t awaddr;
	logic awready;
	logic wvalid;
	data_t wdata;
	strb_t wstrb;
	logic wready;
	logic bvalid;
	resp_t bresp;
	logic bready;

	// master to result stage
	logic m_valid;
	data_t m_rdata;
	logic m_err;
	logic m_write;
	lane_t m_lane;
	mem_size_t m_size;
	logic m_unsigned;

	lsu_align lsu_align_inst (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_write(cmd_write),
		.cmd_size(cmd_size),
		.cmd_unsigned(cmd_unsigned),
		.cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata),
		.busy(busy),
		.a_take(a_take),
		.a_valid(a_valid),
		.a_write(a_write),
		.a_addr(a_addr),
		.a_strb(a_strb),
		.a_wdata(a_wdata),
		.a_lane(a_lane),
		.a_size(a_size),
		.a_unsigned(a_unsigned),
		.a_misaligned(a_misaligned)
	);

	axi_lite_master axi_lite_master_inst (
		.clk(clk),
		.rst(rst),
		.a_valid(a_valid),
		.a_write(a_write),
		.a_addr(a_addr),
		.a_strb(a_strb),
		.a_wdata(a_wdata),
		.a_lane(a_lane),
		.a_size(a_size),
		.a_unsigned(a_unsigned),
		.a_misaligned(a_misaligned),
		.a_take(a_take),
		.arvalid(arvalid),
		.araddr(araddr),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.awready(awready),
		.wvalid(wvalid),
		.wdata(wdata),
		.wstrb(wstrb),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready),
		.m_valid(m_valid),
		.m_rdata(m_rdata),
		.m_err(m_err),
		.m_write(m_write),
		.m_lane(m_lane),
		.m_size(m_size),
		.m_unsigned(m_unsigned)
	);

	axi_sram axi_sram_inst (
		.clk(clk),
		.rst(rst),
		.arvalid(arvalid),
		.araddr(araddr),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready),
		.awvalid(awvalid),
		.awaddr(awaddr),
		.awready(awready),
		.wvalid(wvalid),
		.wdata(wdata),
		.wstrb(wstrb),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready)
	);

	load_extract load_extract_inst (
		.clk(clk),
		.rst(rst),
		.m_valid(m_valid),
		.m_rdata(m_rdata),
		.m_err(m_err),
		.m_write(m_write),
		.m_lane(m_lane),
		.m_size(m_size),
		.m_unsigned(m_unsigned),
		.res_valid(res_valid),
		.res_data(res_data),
		.res_err(res_err)
	);

endmodule

//--- mem_path.f
+incdir+logic
logic/mem_path_pkg.sv
logic/lsu_align.sv
logic/axi_lite_master.sv
logic/axi_sram.sv
logic/load_extract.sv
logic/mem_path_top.sv
bench/clk_gen.sv
bench/mem_path_assert.sv
bench/mem_path_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module mem_path_tb -f mem_path.f \
	--Mdir "$build_dir" -o mem_path_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/mem_path_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TESTS FAILED" "$log_file"; then
	exit 1
fi
exit 0
